/* build.f */
logic/conv_pkg.sv
logic/conv_apb_decode.sv
logic/conv_controller.sv
logic/conv_operand_fetch.sv
logic/conv_mac.sv
logic/psum_buffer.sv
logic/conv_pe_top.sv
testbench/tb_clock_gen.sv
testbench/conv_pe_chk.sv
testbench/conv_pe_tb.sv

/* Makefile */
TOP = conv_pe_tb

all: run

obj_dir/V$(TOP): build.f logic/*.sv testbench/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f build.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q '\*\*\* FAILED \*\*\*' sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "simulation ended early"; exit 1; }

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* testbench/conv_pe_tb.sv */
`timescale 1ns/10ps

module conv_pe_tb import conv_pkg::*; ();

    localparam int N_CASES     = 11;
    localparam int APB_TIMEOUT = 8;       // cycles waiting for pready.
    localparam int DONE_POLLS  = 100;
    localparam int RST_TIMEOUT = 64;

    localparam logic [1:0] SRC_LFSR  = 2'd0;
    localparam logic [1:0] SRC_FIXED = 2'd1;
    localparam logic [1:0] SRC_KEEP  = 2'd2;   // reuse the scratchpads as loaded.

    typedef struct packed {
        conv_mode_e mode;
        logic       clear;
        len_t       in_len;
        logic [2:0] filt_len;
        logic [1:0] src;
    } tcase_t;

    localparam tcase_t CASES [N_CASES] = '{
        '{MODE_STRIDE1,  1'b1, 5'd16, 3'd3, SRC_LFSR},
        '{MODE_STRIDE1,  1'b0, 5'd16, 3'd3, SRC_LFSR},    // adds onto the run above.
        '{MODE_STRIDE2,  1'b1, 5'd16, 3'd1, SRC_LFSR},
        '{MODE_STRIDE2,  1'b1, 5'd15, 3'd2, SRC_FIXED},
        '{MODE_STRIDE2,  1'b1, 5'd16, 3'd3, SRC_LFSR},
        '{MODE_STRIDE2,  1'b0, 5'd11, 3'd4, SRC_LFSR},
        '{MODE_JUST_ADD, 1'b0, 5'd12, 3'd2, SRC_LFSR},
        '{MODE_JUST_ADD, 1'b1, 5'd16, 3'd1, SRC_FIXED},
        '{MODE_STRIDE1,  1'b1, 5'd3,  3'd4, SRC_LFSR},    // filter longer than input.
        '{MODE_STRIDE1,  1'b0, 5'd9,  3'd4, SRC_FIXED},
        '{MODE_STRIDE2,  1'b1, 5'd16, 3'd4, SRC_KEEP}
    };

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] lfsr_state = 32'hfc0caecd;
    data_t       if_ref   [IF_DEPTH];
    data_t       filt_ref [FILT_DEPTH];
    psum_t       psum_ref [IF_DEPTH];
    apb_data_t   ctrl_word;                    // expected CTRL readback.

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    conv_pe_top DUT (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32 + x^22 + x^2 + x + 1.
    endfunction

    task automatic rand_byte(output data_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_psum(input psum_t got, input psum_t exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_data(input apb_data_t got, input apb_data_t exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_err(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    // setup on one falling edge, access on the next, sampled 1 ns later.
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        int waited;
        waited  = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (pready !== 1'b1) begin
            waited++;
            if (waited > APB_TIMEOUT) begin
                stop_run($sformatf("APB transfer to address %h never completed", addr));
            end
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        apb_data_t rd_unused;
        logic      err;
        apb_xfer(1'b1, addr, data, rd_unused, err);
        check_err(err, exp_err, $sformatf("pslverr on write to %h", addr));
    endtask

    task automatic apb_read(input apb_addr_t addr, input logic exp_err, output apb_data_t data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_err(err, exp_err, $sformatf("pslverr on read of %h", addr));
    endtask

    task automatic load_scratch(input logic [1:0] src);
        data_t b;
        for (int i = 0; i < IF_DEPTH; i++) begin
            if (src == SRC_LFSR) begin
                rand_byte(b);
            end else begin
                b = data_t'(8'h81 + 8'(i * 19));
            end
            if_ref[if_addr_t'(i)] = b;
            apb_write(BASE_IF + apb_addr_t'(4 * i), apb_data_t'(b), 1'b0);
        end
        for (int t = 0; t < FILT_DEPTH; t++) begin
            if (src == SRC_LFSR) begin
                rand_byte(b);
            end else begin
                b = data_t'(8'h80 ^ 8'(t * 91));
            end
            filt_ref[filt_addr_t'(t)] = b;
            apb_write(BASE_FILT + apb_addr_t'(4 * t), apb_data_t'(b), 1'b0);
        end
    endtask

    // expected partial sums straight from the mode rules.
    task automatic model_run(input tcase_t tc);
        int    stride;
        int    n_out;
        int    flen;
        int    len;
        psum_t sum;
        flen   = int'(tc.filt_len);
        len    = int'(tc.in_len);
        stride = (tc.mode == MODE_STRIDE2) ? 2 : 1;
        if (tc.clear) begin
            for (int i = 0; i < IF_DEPTH; i++) begin
                psum_ref[if_addr_t'(i)] = '0;
            end
        end
        if (tc.mode == MODE_JUST_ADD) begin
            for (int i = 0; i < len; i++) begin
                psum_ref[if_addr_t'(i)] = psum_ref[if_addr_t'(i)] + psum_t'(if_ref[if_addr_t'(i)]);
            end
        end else begin
            n_out = (len < flen) ? 0 : (len - flen) / stride + 1;
            for (int o = 0; o < n_out; o++) begin
                sum = '0;
                for (int t = 0; t < flen; t++) begin
                    sum = sum + psum_t'(if_ref[if_addr_t'(o * stride + t)])
                              * psum_t'(filt_ref[filt_addr_t'(t)]);
                end
                psum_ref[if_addr_t'(o)] = psum_ref[if_addr_t'(o)] + sum;
            end
        end
    endtask

    task automatic wait_done();
        apb_data_t st;
        int        polls;
        polls = 0;
        st    = '0;
        while (st[1] !== 1'b1) begin
            if (polls >= DONE_POLLS) begin
                stop_run("run never reached done within the poll limit");
            end
            polls++;
            apb_read(REG_STATUS, 1'b0, st);
        end
    endtask

    task automatic check_psums();
        apb_data_t rd;
        for (int i = 0; i < IF_DEPTH; i++) begin
            apb_read(BASE_PSUM + apb_addr_t'(4 * i), 1'b0, rd);
            check_psum(psum_t'(rd), psum_ref[if_addr_t'(i)], $sformatf("psum[%0d]", i));
            check_data(rd, apb_data_t'(psum_ref[if_addr_t'(i)]), $sformatf("psum[%0d] word", i));
        end
    endtask

    task automatic run_case(input tcase_t tc);
        apb_data_t st;
        apb_data_t rd;
        if (tc.src != SRC_KEEP) begin
            load_scratch(tc.src);
        end
        apb_write(REG_CFG, {22'd0, 2'(tc.filt_len - 3'd1), 3'd0, tc.in_len}, 1'b0);
        model_run(tc);
        apb_write(REG_CTRL, {28'd0, tc.mode, tc.clear, 1'b1}, 1'b0);
        ctrl_word = {28'd0, tc.mode, tc.clear, 1'b0};
        apb_read(REG_STATUS, 1'b0, st);
        check_data(st, 32'h1, "status after start");
        if (tc.clear) begin
            // still inside the 16-cycle clear phase.
            apb_write(BASE_IF, ~apb_data_t'(if_ref[0]), 1'b1);
            apb_write(BASE_FILT + 8'h04, ~apb_data_t'(filt_ref[1]), 1'b1);
            apb_write(REG_CFG, 32'h0000_0001, 1'b1);
        end
        wait_done();
        apb_read(REG_STATUS, 1'b0, st);
        check_data(st, 32'h2, "status after done");
        check_psums();
        apb_read(REG_STATUS, 1'b0, st);
        check_data(st, 32'h2, "status held after readback");
        apb_read(REG_CTRL, 1'b0, rd);
        check_data(rd, ctrl_word, "ctrl readback");
    endtask

    task automatic reject_checks();
        apb_data_t rd;
        apb_read(8'h0C, 1'b1, rd);
        apb_write(8'h30, 32'h0000_005a, 1'b1);
        apb_write(8'h42, 32'h0000_0011, 1'b1);                // misaligned.
        apb_write(BASE_FILT + 8'h10, 32'h0000_007f, 1'b1);    // past the filter taps.
        apb_write(BASE_PSUM + 8'h04, 32'h0000_0123, 1'b1);
        apb_write(REG_STATUS, 32'h0000_0000, 1'b1);
        apb_write(REG_CTRL, 32'h0000_000f, 1'b1);             // mode 3 with go.
        apb_read(REG_STATUS, 1'b0, rd);
        check_data(rd, 32'h2, "status after rejected go");
        apb_read(REG_CTRL, 1'b0, rd);
        check_data(rd, ctrl_word, "ctrl after rejected go");
        check_psums();
    endtask

    initial begin
        int        waited;
        apb_data_t st;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        waited  = 0;
        for (int i = 0; i < IF_DEPTH; i++) begin
            psum_ref[if_addr_t'(i)] = '0;
        end
        while (rst !== 1'b0) begin
            if (waited >= RST_TIMEOUT) begin
                stop_run("reset never released");
            end
            waited++;
            @(negedge clk);
        end
        apb_read(REG_STATUS, 1'b0, st);
        check_data(st, 32'h0, "status after reset");
        for (int i = 0; i < N_CASES; i++) begin
            if (CASES[4'(i)].src == SRC_KEEP) begin
                reject_checks();
            end
            run_case(CASES[4'(i)]);
        end
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* testbench/conv_pe_chk.sv */
`timescale 1ns/10ps

module conv_pe_chk (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic busy,
    input logic done,
    input logic psum_clear
);

    a_err_in_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else $error("pslverr raised outside an APB access cycle");

    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready dropped low");

    a_no_clear_when_done: assert property (@(posedge clk) disable iff (rst)
        !(psum_clear && done))
        else $error("psum clear active while done is set");

    a_busy_done_excl: assert property (@(posedge clk) disable iff (rst) !(busy && done))
        else $error("busy and done high together");

endmodule

// the decode carries the bus side.
bind conv_apb_decode conv_pe_chk u_apb_chk (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pready     (pready),
    .pslverr    (pslverr),
    .busy       (busy),
    .done       (done),
    .psum_clear (1'b0)
);

// the controller has no bus pins, so those inputs sit at their idle values.
bind conv_controller conv_pe_chk u_ctrl_chk (
    .clk        (clk),
    .rst        (rst),
    .psel       (1'b0),
    .penable    (1'b0),
    .pready     (1'b1),
    .pslverr    (1'b0),
    .busy       (busy),
    .done       (done),
    .psum_clear (psum_clear)
);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD_NS = 4;    // 8 ns clock.
    localparam int RESET_CYCLES   = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;                       // release away from the rising edge.
    end

endmodule

/* logic/conv_pe_top.sv */
`timescale 1ns/10ps

module conv_pe_top import conv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr
);

    logic        start;
    run_cfg_t    run_cfg;
    scratch_wr_t scratch_wr;
    logic        busy;
    logic        done;
    if_addr_t    psum_raddr;
    psum_t       psum_rdata;
    logic        fetch_start;
    logic        just_add;
    logic        psum_clear;
    logic        all_issued;
    mac_op_t     mac_op;
    psum_wr_t    psum_wr;

    conv_apb_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .done       (done),
        .start      (start),
        .run_cfg    (run_cfg),
        .scratch_wr (scratch_wr),
        .psum_raddr (psum_raddr),
        .psum_rdata (psum_rdata)
    );

    conv_controller u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .run_cfg     (run_cfg),
        .all_issued  (all_issued),
        .fetch_start (fetch_start),
        .just_add    (just_add),
        .psum_clear  (psum_clear),
        .busy        (busy),
        .done        (done)
    );

    conv_operand_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .scratch_wr  (scratch_wr),
        .run_cfg     (run_cfg),
        .fetch_start (fetch_start),
        .just_add    (just_add),
        .mac_op      (mac_op),
        .all_issued  (all_issued)
    );

    conv_mac u_mac (
        .clk     (clk),
        .rst     (rst),
        .mac_op  (mac_op),
        .psum_wr (psum_wr)
    );

    psum_buffer u_psum (
        .clk        (clk),
        .rst        (rst),
        .psum_clear (psum_clear),
        .psum_wr    (psum_wr),
        .raddr      (psum_raddr),
        .rdata      (psum_rdata)
    );

endmodule

/* logic/psum_buffer.sv */
`timescale 1ns/10ps

module psum_buffer import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     psum_clear,
    input  psum_wr_t psum_wr,
    input  if_addr_t raddr,
    output psum_t    rdata
);

    psum_t    mem [IF_DEPTH];
    if_addr_t clr_idx;

    // walks the entries one per cycle while the clear phase lasts.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            clr_idx <= '0;
        end else if (psum_clear) begin
            clr_idx <= clr_idx + 1'b1;
        end else begin
            clr_idx <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (psum_clear) begin
            mem[clr_idx] <= '0;
        end else if (psum_wr.valid) begin
            mem[psum_wr.idx] <= mem[psum_wr.idx] + psum_wr.value;   // wraps at 20 bits.
        end
    end

    assign rdata = mem[raddr];

endmodule

/* logic/conv_mac.sv */
`timescale 1ns/10ps

module conv_mac import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  mac_op_t  mac_op,
    output psum_wr_t psum_wr
);

    logic signed [15:0] product;
    psum_t              acc;          // running window sum.
    psum_t              sum_nxt;
    psum_t              pass_val;

    assign product  = $signed(mac_op.sample) * $signed(mac_op.weight);
    assign sum_nxt  = (mac_op.first_tap ? psum_t'(0) : acc) + psum_t'(product);
    assign pass_val = psum_t'($signed(mac_op.sample));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc     <= '0;
            psum_wr <= '0;
        end else begin
            psum_wr.valid <= mac_op.valid && (mac_op.just_add || mac_op.last_tap);
            psum_wr.idx   <= mac_op.out_idx;
            psum_wr.value <= mac_op.just_add ? pass_val : sum_nxt;
            if (mac_op.valid && !mac_op.just_add) begin
                acc <= sum_nxt;
            end
        end
    end

endmodule

/* logic/conv_operand_fetch.sv */
`timescale 1ns/10ps

module conv_operand_fetch import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  scratch_wr_t scratch_wr,
    input  run_cfg_t    run_cfg,
    input  logic        fetch_start,
    input  logic        just_add,
    output mac_op_t     mac_op,
    output logic        all_issued
);

    data_t      if_mem   [IF_DEPTH];
    data_t      filt_mem [FILT_DEPTH];
    logic       active;
    if_addr_t   base;
    if_addr_t   out_idx;
    filt_addr_t tap;
    if_addr_t   stride;
    len_t       flen;
    len_t       n_out;
    len_t       n_ops;
    logic       win_last;
    logic       run_last;

    always_ff @(posedge clk) begin
        if (scratch_wr.valid) begin
            if (scratch_wr.filt_sel) begin
                filt_mem[scratch_wr.idx[1:0]] <= scratch_wr.data;
            end else begin
                if_mem[scratch_wr.idx] <= scratch_wr.data;
            end
        end
    end

    assign flen   = len_t'(run_cfg.filt_len_m1) + len_t'(1);
    assign stride = (run_cfg.mode == MODE_STRIDE2) ? if_addr_t'(2) : if_addr_t'(1);

    always_comb begin
        if (run_cfg.in_len < flen) begin
            n_out = '0;                              // filter longer than input.
        end else if (run_cfg.mode == MODE_STRIDE2) begin
            n_out = ((run_cfg.in_len - flen) >> 1) + len_t'(1);
        end else begin
            n_out = run_cfg.in_len - flen + len_t'(1);
        end
    end

    assign n_ops    = just_add ? run_cfg.in_len : n_out;
    assign win_last = just_add || tap == run_cfg.filt_len_m1;
    assign run_last = win_last && (len_t'(out_idx) + len_t'(1) == n_ops);

    // just-add holds tap at 0 and steps base by 1, so base tracks out_idx.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active     <= 1'b0;
            base       <= '0;
            out_idx    <= '0;
            tap        <= '0;
            all_issued <= 1'b0;
            mac_op     <= '0;
        end else begin
            all_issued   <= 1'b0;
            mac_op.valid <= 1'b0;
            if (fetch_start) begin
                base       <= '0;
                out_idx    <= '0;
                tap        <= '0;
                active     <= n_ops != '0;
                all_issued <= n_ops == '0;
            end else if (active) begin
                mac_op.valid     <= 1'b1;
                mac_op.sample    <= if_mem[base + if_addr_t'(tap)];
                mac_op.weight    <= just_add ? data_t'(0) : filt_mem[tap];
                mac_op.first_tap <= tap == '0;
                mac_op.last_tap  <= win_last;
                mac_op.out_idx   <= out_idx;
                mac_op.just_add  <= just_add;
                if (win_last) begin
                    tap     <= '0;
                    base    <= base + stride;
                    out_idx <= out_idx + 1'b1;
                end else begin
                    tap <= tap + 1'b1;
                end
                if (run_last) begin
                    active     <= 1'b0;
                    all_issued <= 1'b1;
                end
            end
        end
    end

endmodule

/* logic/conv_controller.sv */
`timescale 1ns/10ps

module conv_controller import conv_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  run_cfg_t run_cfg,
    input  logic     all_issued,
    output logic     fetch_start,
    output logic     just_add,
    output logic     psum_clear,
    output logic     busy,
    output logic     done
);

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    if_addr_t    cnt;          // clear length, then drain length.
    logic        draining;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (start) begin
                    state_nxt = run_cfg.clear ? ST_CLEAR : ST_FETCH;
                end
            end
            ST_CLEAR: begin
                if (cnt == if_addr_t'(IF_DEPTH - 1)) begin
                    state_nxt = ST_FETCH;
                end
            end
            ST_FETCH: state_nxt = just_add ? ST_JUST_ADD : ST_WINDOW;
            ST_WINDOW, ST_JUST_ADD: begin
                if (draining && cnt == if_addr_t'(DRAIN_CYCLES - 1)) begin
                    state_nxt = ST_DONE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            draining <= 1'b0;
            just_add <= 1'b0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    cnt      <= '0;
                    draining <= 1'b0;
                    if (start) begin
                        just_add <= run_cfg.mode == MODE_JUST_ADD;
                    end
                end
                ST_CLEAR: cnt <= cnt + 1'b1;     // wraps back to 0 on exit.
                ST_WINDOW, ST_JUST_ADD: begin
                    if (draining) begin
                        cnt <= cnt + 1'b1;
                    end else if (all_issued) begin
                        draining <= 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        fetch_start = state == ST_FETCH;
        psum_clear  = state == ST_CLEAR;
        done        = state == ST_DONE;
        busy        = !(state == ST_IDLE || state == ST_DONE);
    end

endmodule

/* logic/conv_apb_decode.sv */
`timescale 1ns/10ps

module conv_apb_decode import conv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        busy,
    input  logic        done,
    output logic        start,
    output run_cfg_t    run_cfg,
    output scratch_wr_t scratch_wr,
    output if_addr_t    psum_raddr,
    input  psum_t       psum_rdata
);

    logic       access;
    logic       aligned;
    logic       hit_ctrl;
    logic       hit_cfg;
    logic       hit_status;
    logic       hit_if;
    logic       hit_filt;
    logic       hit_psum;
    logic       mapped;
    logic       wr_err;
    logic       err;
    logic       wr_ok;
    conv_mode_e wr_mode;
    conv_mode_e ctrl_mode;
    logic       ctrl_clear;
    len_t       cfg_in_len;
    filt_addr_t cfg_filt_m1;

    assign access     = psel & penable;
    assign aligned    = paddr[1:0] == 2'b00;
    assign hit_ctrl   = paddr == REG_CTRL;
    assign hit_cfg    = paddr == REG_CFG;
    assign hit_status = paddr == REG_STATUS;
    assign hit_if     = aligned && paddr[7:6] == BASE_IF[7:6];
    assign hit_filt   = aligned && paddr[7:6] == BASE_FILT[7:6] && paddr[5:4] == 2'b00;
    assign hit_psum   = aligned && paddr[7:6] == BASE_PSUM[7:6];
    assign mapped     = hit_ctrl | hit_cfg | hit_status | hit_if | hit_filt | hit_psum;

    assign wr_mode = conv_mode_e'(pwdata[3:2]);

    // status and psum space are read only, scratch and cfg are locked during a run.
    assign wr_err = pwrite && (hit_status || hit_psum
                    || (hit_ctrl && pwdata[0] && pwdata[3:2] == MODE_RSVD)
                    || (busy && (hit_if || hit_filt || hit_cfg)));
    assign err     = !mapped || wr_err;
    assign pslverr = access & err;
    assign wr_ok   = access & pwrite & ~err;
    assign pready  = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start       <= 1'b0;
            ctrl_mode   <= MODE_STRIDE1;
            ctrl_clear  <= 1'b0;
            cfg_in_len  <= '0;
            cfg_filt_m1 <= '0;
        end else begin
            start <= 1'b0;
            if (wr_ok && hit_ctrl && !busy) begin   // go while busy is dropped.
                ctrl_mode  <= wr_mode;
                ctrl_clear <= pwdata[1];
                start      <= pwdata[0];
            end
            if (wr_ok && hit_cfg) begin
                cfg_in_len  <= pwdata[4:0];
                cfg_filt_m1 <= pwdata[9:8];
            end
        end
    end

    assign run_cfg = '{mode: ctrl_mode, clear: ctrl_clear,
                       in_len: cfg_in_len, filt_len_m1: cfg_filt_m1};

    always_comb begin
        scratch_wr.valid    = wr_ok && (hit_if || hit_filt);
        scratch_wr.filt_sel = hit_filt;
        scratch_wr.idx      = paddr[5:2];
        scratch_wr.data     = pwdata[7:0];
    end

    assign psum_raddr = paddr[5:2];

    // scratchpads are write only and read back as zero.
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[3:1] = {ctrl_mode, ctrl_clear};
        end else if (hit_cfg) begin
            prdata[4:0] = cfg_in_len;
            prdata[9:8] = cfg_filt_m1;
        end else if (hit_status) begin
            prdata[1:0] = {done, busy};
        end else if (hit_psum) begin
            prdata = apb_data_t'(psum_rdata);       // sign-extended.
        end
    end

endmodule

/* logic/conv_pkg.sv */
package conv_pkg;

    typedef logic signed [7:0]  data_t;
    typedef logic signed [19:0] psum_t;
    typedef logic [3:0]         if_addr_t;
    typedef logic [1:0]         filt_addr_t;
    typedef logic [4:0]         len_t;        // lengths and counts 0..16.
    typedef logic [7:0]         apb_addr_t;
    typedef logic [31:0]        apb_data_t;

    localparam int IF_DEPTH     = 16;
    localparam int FILT_DEPTH   = 4;
    localparam int DRAIN_CYCLES = 2;          // fetch register to psum write landing.

    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_CFG    = 8'h04;
    localparam apb_addr_t REG_STATUS = 8'h08;
    localparam apb_addr_t BASE_IF    = 8'h40;
    localparam apb_addr_t BASE_FILT  = 8'h80;
    localparam apb_addr_t BASE_PSUM  = 8'hC0;

    localparam logic [1:0] MODE_RSVD = 2'b11;

    typedef enum logic [1:0] {
        MODE_STRIDE1  = 2'd0,
        MODE_STRIDE2  = 2'd1,
        MODE_JUST_ADD = 2'd2
    } conv_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_FETCH,
        ST_WINDOW,
        ST_JUST_ADD,
        ST_DONE
    } ctrl_state_e;

    typedef struct packed {
        conv_mode_e mode;
        logic       clear;
        len_t       in_len;
        filt_addr_t filt_len_m1;
    } run_cfg_t;

    typedef struct packed {
        logic     valid;
        logic     filt_sel;   // 1 selects the filter scratchpad.
        if_addr_t idx;
        data_t    data;
    } scratch_wr_t;

    typedef struct packed {
        logic     valid;
        data_t    sample;
        data_t    weight;
        logic     first_tap;
        logic     last_tap;
        if_addr_t out_idx;
        logic     just_add;
    } mac_op_t;

    typedef struct packed {
        logic     valid;
        if_addr_t idx;
        psum_t    value;
    } psum_wr_t;

endpackage
